//--- Makefile
TOP       ?= softmax_tb
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary -Wno-fatal $(FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- design/denom_accumulator.sv
`timescale 1ns/1ps
`include "softmax_settings.svh"

module denom_accumulator
    import softmax_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        clear_i,
    input  logic        w_valid_i,
    input  weight_vec_t w_data_i,
    input  shift_t      w_shift_i,
    output acc_t        denom_o
);

    localparam int PAIRS = `SMX_LANES / 2;

    logic [`SMX_FRAC+1:0] pair_sum [PAIRS];
    acc_t                 beat_sum;
    acc_t                 denom_q;
    acc_t                 denom_scaled;

    // First tree level adds neighbouring lanes
    always_comb begin
        for (int j = 0; j < PAIRS; j++) begin
            pair_sum[j] = {1'b0, w_data_i[2*j]} + {1'b0, w_data_i[2*j+1]};
        end
    end

    always_comb begin
        beat_sum = '0;
        for (int j = 0; j < PAIRS; j++) begin
            beat_sum = beat_sum + acc_t'(pair_sum[j]);
        end
    end

    // Old sum moves to the new max before the beat is added
    always_comb begin
        if (w_shift_i >= shift_t'(`SMX_ACC_W)) begin
            denom_scaled = '0;
        end else begin
            denom_scaled = denom_q >> w_shift_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (~rst_ni) begin
            denom_q <= '0;
        end else if (clear_i) begin
            denom_q <= '0;
        end else if (w_valid_i) begin
            denom_q <= denom_scaled + beat_sum;
        end
    end

    assign denom_o = denom_q;

endmodule

//--- design/lane_arbiter.sv
`timescale 1ns/1ps

module lane_arbiter
    import softmax_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        clear_i,
    input  logic        new_valid_i,
    input  score_vec_t  new_scores_i,
    input  strb_t       new_strb_i,
    input  score_t      new_max_i,
    input  shift_t      new_shift_i,
    output logic        new_ready_o,
    input  logic        wait_valid_i,
    input  weight_vec_t wait_weights_i,
    input  strb_t       wait_strb_i,
    output logic        wait_ready_o,
    input  logic        inv_valid_i,
    output logic        req_valid_o,
    output lane_op_e    req_op_o,
    output score_vec_t  req_scores_o,
    output weight_vec_t req_weights_o,
    output strb_t       req_strb_o,
    output score_t      req_max_o,
    output shift_t      req_shift_o,
    input  logic        req_ready_i
);

    logic        slot_q;
    weight_vec_t slot_weights_q;
    strb_t       slot_strb_q;
    logic        grant_slot;
    logic        slot_push;
    logic        slot_pop;

    // Waiting beat wins whenever the inverse is available
    assign grant_slot = slot_q & inv_valid_i;

    assign req_valid_o   = grant_slot | new_valid_i;
    assign req_op_o      = grant_slot ? OP_SCALE : OP_WEIGHT;
    assign req_scores_o  = new_scores_i;
    assign req_weights_o = slot_weights_q;
    assign req_strb_o    = grant_slot ? slot_strb_q : new_strb_i;
    assign req_max_o     = new_max_i;
    assign req_shift_o   = grant_slot ? '0 : new_shift_i;
    assign new_ready_o   = ~grant_slot & req_ready_i;

    // A granted slot can refill in the same cycle it drains
    assign wait_ready_o = ~slot_q | grant_slot;
    assign slot_push    = wait_valid_i & wait_ready_o;
    assign slot_pop     = grant_slot & req_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (~rst_ni) begin
            slot_q <= 1'b0;
        end else if (clear_i) begin
            slot_q <= 1'b0;
        end else if (slot_push) begin
            slot_q <= 1'b1;
        end else if (slot_pop) begin
            slot_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (slot_push) begin
            slot_weights_q <= wait_weights_i;
            slot_strb_q    <= wait_strb_i;
        end
    end

endmodule

//--- design/max_tracker.sv
`timescale 1ns/1ps
`include "softmax_settings.svh"

module max_tracker
    import softmax_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       clear_i,
    input  logic       norm_mode_i,
    input  logic       in_valid_i,
    input  score_vec_t in_scores_i,
    input  strb_t      in_strb_i,
    output logic       in_ready_o,
    output logic       beat_valid_o,
    input  logic       beat_ready_i,
    output score_vec_t beat_scores_o,
    output strb_t      beat_strb_o,
    output score_t     beat_max_o,
    output shift_t     beat_shift_o,
    output score_t     max_o
);

    score_t max_q;
    score_t beat_peak;
    score_t next_max;
    logic   in_fire;

    // Largest score among strobed lanes
    always_comb begin
        beat_peak = '0;
        for (int i = 0; i < `SMX_LANES; i++) begin
            if (in_strb_i[i] && (in_scores_i[i] > beat_peak)) begin
                beat_peak = in_scores_i[i];
            end
        end
    end

    // Max is frozen while normalizing
    assign next_max   = (!norm_mode_i && (beat_peak > max_q)) ? beat_peak : max_q;
    assign in_ready_o = ~beat_valid_o | beat_ready_i;
    assign in_fire    = in_valid_i & in_ready_o;
    assign max_o      = max_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (~rst_ni) begin
            max_q        <= '0;
            beat_valid_o <= 1'b0;
        end else if (clear_i) begin
            max_q        <= '0;
            beat_valid_o <= 1'b0;
        end else if (in_fire) begin
            max_q        <= next_max;
            beat_valid_o <= 1'b1;
        end else if (beat_ready_i) begin
            beat_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_fire) begin
            beat_scores_o <= in_scores_i;
            beat_strb_o   <= in_strb_i;
            beat_max_o    <= next_max;
            beat_shift_o  <= shift_t'(next_max - max_q);
        end
    end

endmodule

//--- design/recip_divider.sv
`timescale 1ns/1ps
`include "softmax_settings.svh"

module recip_divider
    import softmax_pkg::*;
(
    input  logic clk_i,
    input  logic rst_ni,
    input  logic clear_i,
    input  logic start_i,
    input  acc_t denom_i,
    output inv_t inv_o,
    output logic inv_valid_o,
    output logic busy_o
);

    // Dividend is 2^(2*FRAC) and each step yields one quotient bit
    localparam int QW = 2 * `SMX_FRAC + 1;
    localparam int CW = $clog2(QW);

    acc_t                div_q;
    acc_t                rem_q;
    logic [QW-1:0]       quo_q;
    logic [CW-1:0]       cnt_q;
    logic                busy_q;
    logic                valid_q;
    inv_t                inv_q;
    logic [`SMX_ACC_W:0] rem_sh;
    logic                fits;
    acc_t                rem_nxt;
    logic [QW-1:0]       quo_nxt;
    inv_t                quo_sat;

    assign rem_sh  = {rem_q, quo_q[QW-1]};
    assign fits    = rem_sh >= {1'b0, div_q};
    assign rem_nxt = fits ? acc_t'(rem_sh - {1'b0, div_q}) : rem_sh[`SMX_ACC_W-1:0];
    assign quo_nxt = {quo_q[QW-2:0], fits};
    // A zero divisor yields all ones and lands here too
    assign quo_sat = (|quo_nxt[QW-1:`SMX_INV_W]) ? '1 : quo_nxt[`SMX_INV_W-1:0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (~rst_ni) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
            cnt_q   <= '0;
            inv_q   <= '0;
        end else if (clear_i) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
            cnt_q   <= '0;
            inv_q   <= '0;
        end else if (start_i) begin
            busy_q  <= 1'b1;
            valid_q <= 1'b0;
            cnt_q   <= '0;
        end else if (busy_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CW'(QW - 1)) begin
                busy_q  <= 1'b0;
                valid_q <= 1'b1;
                inv_q   <= quo_sat;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            div_q <= denom_i;
            rem_q <= '0;
            quo_q <= QW'(1) << (QW - 1);
        end else if (busy_q) begin
            rem_q <= rem_nxt;
            quo_q <= quo_nxt;
        end
    end

    assign inv_o       = inv_q;
    assign inv_valid_o = valid_q;
    assign busy_o      = busy_q;

endmodule

//--- design/shared_lane_unit.sv
`timescale 1ns/1ps
`include "softmax_settings.svh"

module shared_lane_unit
    import softmax_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        clear_i,
    input  logic        req_valid_i,
    input  lane_op_e    req_op_i,
    input  score_vec_t  req_scores_i,
    input  weight_vec_t req_weights_i,
    input  strb_t       req_strb_i,
    input  score_t      req_max_i,
    input  shift_t      req_shift_i,
    output logic        req_ready_o,
    input  inv_t        inv_i,
    output logic        res_valid_o,
    output lane_op_e    res_op_o,
    output weight_vec_t res_data_o,
    output strb_t       res_strb_o,
    output shift_t      res_shift_o,
    input  logic        res_ready_i
);

    localparam weight_t ONE_W = weight_t'(1 << `SMX_FRAC);

    shift_t                          lane_diff;
    weight_t                         lane_weight;
    logic [`SMX_FRAC+`SMX_INV_W:0]   lane_prod;
    weight_vec_t                     lane_res;
    logic                            req_fire;

    always_comb begin
        for (int i = 0; i < `SMX_LANES; i++) begin
            // Scores above the max are treated as equal to it
            if (req_scores_i[i] > req_max_i) begin
                lane_diff = '0;
            end else begin
                lane_diff = shift_t'(req_max_i - req_scores_i[i]);
            end
            lane_weight = (lane_diff > shift_t'(`SMX_FRAC)) ? '0 : (ONE_W >> lane_diff);
            lane_prod   = req_weights_i[i] * inv_i;
            if (!req_strb_i[i]) begin
                lane_res[i] = '0;
            end else if (req_op_i == OP_SCALE) begin
                lane_res[i] = weight_t'(lane_prod >> `SMX_FRAC);
            end else begin
                lane_res[i] = lane_weight;
            end
        end
    end

    assign req_ready_o = ~res_valid_o | res_ready_i;
    assign req_fire    = req_valid_i & req_ready_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (~rst_ni) begin
            res_valid_o <= 1'b0;
        end else if (clear_i) begin
            res_valid_o <= 1'b0;
        end else if (req_fire) begin
            res_valid_o <= 1'b1;
        end else if (res_ready_i) begin
            res_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            res_op_o    <= req_op_i;
            res_data_o  <= lane_res;
            res_strb_o  <= req_strb_i;
            res_shift_o <= req_shift_i;
        end
    end

endmodule

//--- design/softmax_pkg.sv
`include "softmax_settings.svh"

package softmax_pkg;

    typedef logic [`SMX_SCORE_W-1:0] score_t;

    // Weight or probability with one integer bit above the fraction
    typedef logic [`SMX_FRAC:0] weight_t;

    // Max differences never exceed the score range
    typedef logic [`SMX_SCORE_W-1:0] shift_t;

    typedef logic [`SMX_ACC_W-1:0] acc_t;

    typedef logic [`SMX_INV_W-1:0] inv_t;

    typedef logic [`SMX_LANES-1:0] strb_t;

    typedef score_t [`SMX_LANES-1:0] score_vec_t;

    typedef weight_t [`SMX_LANES-1:0] weight_vec_t;

    // Operation performed by the shared lane unit
    typedef enum logic {
        OP_WEIGHT,
        OP_SCALE
    } lane_op_e;

endpackage

//--- design/softmax_settings.svh
`ifndef SOFTMAX_SETTINGS_SVH
`define SOFTMAX_SETTINGS_SVH

// Lanes carried by one stream beat
`define SMX_LANES 4

// Unsigned score width per lane
`define SMX_SCORE_W 8

// A full weight is 2^SMX_FRAC
`define SMX_FRAC 15

// Denominator accumulator width
`define SMX_ACC_W 24

// Inverse of the denominator, saturated
`define SMX_INV_W 16

`endif

//--- design/softmax_top.sv
`timescale 1ns/1ps

module softmax_top
    import softmax_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        clear_i,
    input  logic        norm_mode_i,
    input  logic        finish_i,
    input  logic        in_valid_i,
    input  score_vec_t  in_scores_i,
    input  strb_t       in_strb_i,
    output logic        in_ready_o,
    output logic        out_valid_o,
    output weight_vec_t out_prob_o,
    output strb_t       out_strb_o,
    input  logic        out_ready_i,
    output acc_t        denom_o,
    output inv_t        inv_o,
    output logic        inv_valid_o,
    output logic        div_busy_o
);

    logic        beat_valid, beat_ready;
    score_vec_t  beat_scores;
    strb_t       beat_strb;
    score_t      beat_max;
    shift_t      beat_shift;
    logic        wait_valid, wait_ready;
    logic        req_valid, req_ready;
    lane_op_e    req_op;
    score_vec_t  req_scores;
    weight_vec_t req_weights;
    strb_t       req_strb;
    score_t      req_max;
    shift_t      req_shift;
    logic        res_valid, res_ready;
    lane_op_e    res_op;
    weight_vec_t res_data;
    strb_t       res_strb;
    shift_t      res_shift;
    logic        res_is_scale;
    logic        acc_valid;

    max_tracker i_max_tracker (
        .clk_i (clk_i), .rst_ni (rst_ni), .clear_i (clear_i), .norm_mode_i (norm_mode_i),
        .in_valid_i (in_valid_i), .in_scores_i (in_scores_i), .in_strb_i (in_strb_i),
        .in_ready_o (in_ready_o), .beat_valid_o (beat_valid), .beat_ready_i (beat_ready),
        .beat_scores_o (beat_scores), .beat_strb_o (beat_strb), .beat_max_o (beat_max),
        .beat_shift_o (beat_shift), .max_o ()
    );

    lane_arbiter i_lane_arbiter (
        .clk_i (clk_i), .rst_ni (rst_ni), .clear_i (clear_i),
        .new_valid_i (beat_valid), .new_scores_i (beat_scores), .new_strb_i (beat_strb),
        .new_max_i (beat_max), .new_shift_i (beat_shift), .new_ready_o (beat_ready),
        .wait_valid_i (wait_valid), .wait_weights_i (res_data), .wait_strb_i (res_strb),
        .wait_ready_o (wait_ready), .inv_valid_i (inv_valid_o),
        .req_valid_o (req_valid), .req_op_o (req_op), .req_scores_o (req_scores),
        .req_weights_o (req_weights), .req_strb_o (req_strb), .req_max_o (req_max),
        .req_shift_o (req_shift), .req_ready_i (req_ready)
    );

    shared_lane_unit i_shared_lane_unit (
        .clk_i (clk_i), .rst_ni (rst_ni), .clear_i (clear_i),
        .req_valid_i (req_valid), .req_op_i (req_op), .req_scores_i (req_scores),
        .req_weights_i (req_weights), .req_strb_i (req_strb), .req_max_i (req_max),
        .req_shift_i (req_shift), .req_ready_o (req_ready), .inv_i (inv_o),
        .res_valid_o (res_valid), .res_op_o (res_op), .res_data_o (res_data),
        .res_strb_o (res_strb), .res_shift_o (res_shift), .res_ready_i (res_ready)
    );

    // Weights feed the sum or the scale slot and scaled beats leave the design
    assign res_is_scale = (res_op == OP_SCALE);
    assign wait_valid   = res_valid & ~res_is_scale & norm_mode_i;
    assign acc_valid    = res_valid & ~res_is_scale & ~norm_mode_i;
    assign res_ready    = res_is_scale ? out_ready_i : (~norm_mode_i | wait_ready);
    assign out_valid_o  = res_valid & res_is_scale;
    assign out_prob_o   = res_data;
    assign out_strb_o   = res_strb;

    denom_accumulator i_denom_accumulator (
        .clk_i (clk_i), .rst_ni (rst_ni), .clear_i (clear_i),
        .w_valid_i (acc_valid), .w_data_i (res_data), .w_shift_i (res_shift),
        .denom_o (denom_o)
    );

    recip_divider i_recip_divider (
        .clk_i (clk_i), .rst_ni (rst_ni), .clear_i (clear_i),
        .start_i (finish_i), .denom_i (denom_o),
        .inv_o (inv_o), .inv_valid_o (inv_valid_o), .busy_o (div_busy_o)
    );

endmodule

//--- project.f
+incdir+design
design/softmax_pkg.sv
design/max_tracker.sv
design/lane_arbiter.sv
design/shared_lane_unit.sv
design/denom_accumulator.sv
design/recip_divider.sv
design/softmax_top.sv
tests/softmax_chk.sv
tests/softmax_tb.sv

//--- tests/softmax_chk.sv
`timescale 1ns/1ps

module softmax_chk
    import softmax_pkg::*;
(
    input logic        clk_i,
    input logic        rst_ni,
    input logic        clear_i,
    input logic        finish_i,
    input logic        in_valid_i,
    input logic        in_ready_o,
    input score_vec_t  in_scores_i,
    input strb_t       in_strb_i,
    input logic        out_valid_o,
    input logic        out_ready_i,
    input weight_vec_t out_prob_o,
    input strb_t       out_strb_o,
    input logic        inv_valid_o
);

    in_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
        in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_scores_i) && $stable(in_strb_i))
        else $error("input beat dropped or changed while stalled");

    out_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_prob_o) && $stable(out_strb_o))
        else $error("output beat dropped or changed while stalled");

    // Divider result shows up on the 32nd cycle after the start pulse
    inv_after_finish_a: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
        $rose(finish_i) |-> ##32 inv_valid_o)
        else $error("inverse not valid 32 cycles after finish");

    inv_rise_a: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
        $rose(inv_valid_o) |-> $past(finish_i, 32))
        else $error("inverse became valid without a finish pulse 32 cycles earlier");

endmodule

bind softmax_top softmax_chk i_softmax_chk (
    .clk_i (clk_i), .rst_ni (rst_ni), .clear_i (clear_i), .finish_i (finish_i),
    .in_valid_i (in_valid_i), .in_ready_o (in_ready_o), .in_scores_i (in_scores_i),
    .in_strb_i (in_strb_i), .out_valid_o (out_valid_o), .out_ready_i (out_ready_i),
    .out_prob_o (out_prob_o), .out_strb_o (out_strb_o), .inv_valid_o (inv_valid_o)
);

//--- tests/softmax_tb.sv
`timescale 1ns/1ps
`include "softmax_settings.svh"

module softmax_tb
    import softmax_pkg::*;
();

    localparam int ROWS       = 6;
    localparam int BEATS      = 3;
    localparam int MAX_CYCLES = 200 * ROWS;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        clear_i;
    logic        norm_mode_i;
    logic        finish_i;
    logic        in_valid_i;
    score_vec_t  in_scores_i;
    strb_t       in_strb_i;
    logic        out_ready_i = 1'b1;
    logic        in_ready_o;
    logic        out_valid_o;
    weight_vec_t out_prob_o;
    strb_t       out_strb_o;
    acc_t        denom_o;
    inv_t        inv_o;
    logic        inv_valid_o;
    logic        div_busy_o;

    int          seed = 32'h4ca2_e973;
    logic        bp_en = 1'b0;
    int          cycles = 0;
    string       row_name [ROWS];
    score_vec_t  row_scores [ROWS][BEATS];
    strb_t       row_strb [ROWS][BEATS];
    int          exp_denom [ROWS];
    int          exp_inv [ROWS];
    weight_vec_t exp_prob [ROWS][BEATS];

    softmax_top dut_i (.*);

    always #5 clk_i = ~clk_i;

    // Random stalls on the output only while enabled
    always @(posedge clk_i) begin
        out_ready_i <= #1 (bp_en ? 1'($random(seed)) : 1'b1);
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("*** TEST FAILED ***");
            $fatal(1, "Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    function automatic score_vec_t lanes(input int a0, input int a1, input int a2, input int a3);
        return {score_t'(a3), score_t'(a2), score_t'(a1), score_t'(a0)};
    endfunction

    function automatic score_vec_t rand_lanes(input int base, input int mask);
        score_vec_t v;
        for (int l = 0; l < `SMX_LANES; l++) begin
            v[l] = score_t'(base + ($random(seed) & mask));
        end
        return v;
    endfunction

    // Base-2 weight of a lane sitting diff below the max
    function automatic int lane_weight(input int max_v, input int score);
        int diff;
        diff = max_v - score;
        if (diff > `SMX_FRAC) begin
            return 0;
        end
        return (1 << `SMX_FRAC) >> diff;
    endfunction

    task automatic load_rows();
        row_name[0] = "equal_scores";
        row_scores[0] = '{lanes(10, 10, 10, 10), lanes(10, 10, 10, 10), lanes(10, 10, 10, 10)};
        row_strb[0]   = '{4'hf, 4'hf, 4'hf};
        row_name[1] = "rising_max";
        row_scores[1] = '{lanes(5, 3, 1, 0), lanes(9, 8, 2, 7), lanes(30, 12, 29, 25)};
        row_strb[1]   = '{4'hf, 4'hf, 4'hf};
        row_name[2] = "partial_strobes";
        row_scores[2] = '{lanes(40, 200, 38, 255), lanes(37, 250, 41, 1), lanes(99, 99, 99, 99)};
        row_strb[2]   = '{4'b0101, 4'b1101, 4'b0000};
        row_name[3] = "wide_spread";
        row_scores[3] = '{lanes(200, 0, 100, 190), lanes(255, 180, 240, 250), lanes(10, 20, 30, 40)};
        row_strb[3]   = '{4'hf, 4'b1011, 4'hf};
        row_name[4] = "random_full";
        row_name[5] = "random_near";
        for (int b = 0; b < BEATS; b++) begin
            row_scores[4][b] = rand_lanes(0, 255);
            row_strb[4][b]   = strb_t'($random(seed));
            row_scores[5][b] = rand_lanes(100, 15);
            row_strb[5][b]   = strb_t'($random(seed));
        end
    endtask

    task automatic model_row(input int r);
        int max_v;
        int peak;
        int denom;
        int inv;
        max_v = 0;
        denom = 0;
        for (int b = 0; b < BEATS; b++) begin
            peak = 0;
            for (int l = 0; l < `SMX_LANES; l++) begin
                if (row_strb[r][b][l] && row_scores[r][b][l] > peak) begin
                    peak = row_scores[r][b][l];
                end
            end
            // A higher max rescales what was summed so far
            if (peak > max_v) begin
                denom = (peak - max_v >= `SMX_ACC_W) ? 0 : denom >> (peak - max_v);
                max_v = peak;
            end
            for (int l = 0; l < `SMX_LANES; l++) begin
                if (row_strb[r][b][l]) begin
                    denom += lane_weight(max_v, row_scores[r][b][l]);
                end
            end
        end
        inv = (denom == 0) ? 65535 : (1 << 30) / denom;
        exp_denom[r] = denom;
        exp_inv[r] = (inv > 65535) ? 65535 : inv;
        for (int b = 0; b < BEATS; b++) begin
            for (int l = 0; l < `SMX_LANES; l++) begin
                exp_prob[r][b][l] = !row_strb[r][b][l] ? '0 : weight_t'(
                    (longint'(lane_weight(max_v, row_scores[r][b][l])) * exp_inv[r]) >> `SMX_FRAC);
            end
        end
    endtask

    task automatic send_beat(input score_vec_t scores, input strb_t strb);
        in_valid_i  = 1'b1;
        in_scores_i = scores;
        in_strb_i   = strb;
        #1;
        while (!in_ready_o) begin
            @(posedge clk_i);
            #2;
        end
        @(posedge clk_i);
        #1;
        in_valid_i = 1'b0;
    endtask

    // Transfer is decided mid cycle and takes place on the next edge
    task automatic collect_beats(input int r);
        int k;
        k = 0;
        while (k < BEATS) begin
            @(posedge clk_i);
            #2;
            if (out_valid_o && out_ready_i) begin
                for (int l = 0; l < `SMX_LANES; l++) begin
                    check_value($sformatf("%s beat %0d lane %0d", row_name[r], k, l),
                                exp_prob[r][k][l], out_prob_o[l]);
                end
                check_value($sformatf("%s beat %0d strobes", row_name[r], k),
                            row_strb[r][k], out_strb_o);
                k++;
            end
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic normalize_pass(input int r, input logic with_bp);
        bp_en = with_bp;
        fork
            for (int b = 0; b < BEATS; b++) send_beat(row_scores[r][b], row_strb[r][b]);
            collect_beats(r);
        join
        bp_en = 1'b0;
    endtask

    task automatic run_row(input int r);
        int waited;
        clear_i = 1'b1;
        @(posedge clk_i);
        #1;
        clear_i = 1'b0;
        check_value({row_name[r], " cleared denom"}, 0, denom_o);
        check_value({row_name[r], " cleared inv_valid"}, 0, inv_valid_o);
        for (int b = 0; b < BEATS; b++) begin
            send_beat(row_scores[r][b], row_strb[r][b]);
        end
        // Tracker, lane unit and accumulator each add one register stage
        repeat (3) @(posedge clk_i);
        #1;
        check_value({row_name[r], " denom"}, exp_denom[r], denom_o);
        finish_i = 1'b1;
        waited = 0;
        do begin
            @(posedge clk_i);
            #1;
            finish_i = 1'b0;
            waited++;
        end while (!inv_valid_o && waited < 40);
        check_value({row_name[r], " inverse latency"}, 32, waited);
        check_value({row_name[r], " inverse"}, exp_inv[r], inv_o);
        norm_mode_i = 1'b1;
        normalize_pass(r, 1'b0);
        normalize_pass(r, 1'b1);
        norm_mode_i = 1'b0;
    endtask

    initial begin
        rst_ni      = 1'b0;
        clear_i     = 1'b0;
        norm_mode_i = 1'b0;
        finish_i    = 1'b0;
        in_valid_i  = 1'b0;
        in_scores_i = '0;
        in_strb_i   = '0;
        load_rows();
        for (int r = 0; r < ROWS; r++) begin
            model_row(r);
        end
        repeat (4) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        check_value("reset out_valid_o", 0, out_valid_o);
        check_value("reset inv_valid_o", 0, inv_valid_o);
        check_value("reset div_busy_o", 0, div_busy_o);
        check_value("reset in_ready_o", 1, in_ready_o);
        for (int r = 0; r < ROWS; r++) begin
            run_row(r);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
